//--- hdl/branch_pkg.sv
`default_nettype none

package branch_pkg;

	localparam int xlen      = 32;
	localparam int prf_len   = 6;
	localparam int rob_len   = 5;
	localparam int lht_len   = 4; // log2 of local history entries
	localparam int lhist_len = 4;
	localparam int ghist_len = 6; // also the gshare index width

	localparam int lht_size = 1 << lht_len;
	localparam int lpt_size = 1 << lhist_len; // one counter per history pattern
	localparam int gpt_size = 1 << ghist_len;

	typedef logic [xlen-1:0]      word_t;
	typedef logic [prf_len-1:0]   preg_idx_t;
	typedef logic [rob_len-1:0]   rob_idx_t;
	typedef logic [2:0]           br_func_t; // funct3 of the branch
	typedef logic [lhist_len-1:0] lhist_t;
	typedef logic [ghist_len-1:0] ghist_t;
	typedef logic [1:0]           ctr_t;

	localparam ctr_t ctr_init = 2'b01; // weakly not taken

	typedef struct packed {
		word_t     pc;
		word_t     opa_value;
		word_t     opb_value;
		word_t     offset;
		br_func_t  branch_func;
		logic      cond_branch;
		logic      uncond_branch; // jal or jalr
		logic      is_jalr;
		preg_idx_t dest_preg_idx;
		rob_idx_t  rob_idx;
		word_t     pred_target_pc;
		logic      local_pred_direction;
		logic      global_pred_direction;
	} rs_branch_packet_t;

	typedef struct packed {
		logic      direction; // 1 taken
		word_t     target_pc;
		preg_idx_t prf_idx;
		word_t     value; // link value
		rob_idx_t  rob_idx;
		logic      mis_pred;
		logic      local_pred_direction;
		logic      global_pred_direction;
		word_t     pc;
	} br_result_t;

endpackage

`default_nettype wire

//--- hdl/brcond.sv
`timescale 1ns/100ps
`default_nettype none

module brcond (
	input  branch_pkg::word_t    rs1,
	input  branch_pkg::word_t    rs2,
	input  branch_pkg::br_func_t branch_func,
	output logic                 cond
);

	logic signed_lt;
	logic unsigned_lt;

	assign signed_lt   = $signed(rs1) < $signed(rs2);
	assign unsigned_lt = rs1 < rs2;

	always_comb begin
		cond = 1'b0; // 010 and 011 are not branches
		case (branch_func)
			3'b000: cond = rs1 == rs2; // beq
			3'b001: cond = rs1 != rs2; // bne
			3'b100: cond = signed_lt; // blt
			3'b101: cond = !signed_lt; // bge
			3'b110: cond = unsigned_lt; // bltu
			3'b111: cond = !unsigned_lt; // bgeu
			default: cond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
	input  branch_pkg::rs_branch_packet_t rs_branch_packet,
	output branch_pkg::br_result_t        br_result
);

	logic              br_cond;
	logic              direction;
	branch_pkg::word_t link_pc;
	branch_pkg::word_t target_pc;

	brcond brcond_i (
		.rs1         (rs_branch_packet.opa_value),
		.rs2         (rs_branch_packet.opb_value),
		.branch_func (rs_branch_packet.branch_func),
		.cond        (br_cond)
	);

	assign link_pc   = rs_branch_packet.pc + 32'd4;
	assign direction = rs_branch_packet.uncond_branch ? 1'b1 : br_cond; // jumps always taken

	always_comb begin
		if (!direction) begin
			target_pc = link_pc; // fall through
		end else if (rs_branch_packet.is_jalr) begin
			target_pc = rs_branch_packet.opa_value + rs_branch_packet.offset;
		end else begin
			target_pc = rs_branch_packet.pc + rs_branch_packet.offset;
		end
	end

	always_comb begin
		br_result.direction = direction;
		br_result.target_pc = target_pc;
		br_result.prf_idx   = rs_branch_packet.dest_preg_idx;
		// only jumps write a link register
		br_result.value     = rs_branch_packet.uncond_branch ? link_pc : '0;
		br_result.rob_idx   = rs_branch_packet.rob_idx;
		br_result.mis_pred  = rs_branch_packet.pred_target_pc != target_pc;
		br_result.local_pred_direction  = rs_branch_packet.local_pred_direction;
		br_result.global_pred_direction = rs_branch_packet.global_pred_direction;
		br_result.pc        = rs_branch_packet.pc;
	end

endmodule

`default_nettype wire

//--- hdl/branch_result_reg.sv
`timescale 1ns/100ps
`default_nettype none

module branch_result_reg (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   branch_enable,
	input  logic                   cond_branch,
	input  branch_pkg::br_result_t br_result_in,
	output logic                   br_valid,
	output logic                   br_train,
	output branch_pkg::br_result_t br_result
);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			br_valid <= 1'b0;
			br_train <= 1'b0;
		end else begin
			br_valid <= branch_enable; // one cycle broadcast
			br_train <= branch_enable && cond_branch; // jumps don't train
		end
	end

	always_ff @(posedge clock) begin
		if (branch_enable) begin
			br_result <= br_result_in;
		end
	end

	// consumers sample the payload in the valid cycle only
	result_known_when_valid: assert property (
		@(posedge clock) disable iff (!rst_n)
		br_valid |-> !$isunknown(br_result)
	);

endmodule

`default_nettype wire

//--- hdl/branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor (
	input  logic              clock,
	input  logic              rst_n,
	input  branch_pkg::word_t fetch_pc,
	output logic              local_pred_taken,
	output logic              global_pred_taken,
	input  logic              train,
	input  branch_pkg::word_t train_pc,
	input  logic              train_taken
);

	branch_pkg::lhist_t lht [branch_pkg::lht_size]; // per-pc local history
	branch_pkg::ctr_t   lpt [branch_pkg::lpt_size]; // local pattern counters
	branch_pkg::ctr_t   gpt [branch_pkg::gpt_size]; // gshare counters
	branch_pkg::ghist_t ghist;

	logic [branch_pkg::lht_len-1:0] fetch_lht_idx;
	logic [branch_pkg::lht_len-1:0] train_lht_idx;
	branch_pkg::lhist_t             fetch_lhist;
	branch_pkg::lhist_t             train_lhist;
	branch_pkg::ghist_t             fetch_g_idx;
	branch_pkg::ghist_t             train_g_idx;

	function automatic branch_pkg::ctr_t ctr_next(
		input branch_pkg::ctr_t ctr,
		input logic             taken
	);
		ctr_next = ctr;
		if (taken && ctr != 2'b11) begin
			ctr_next = ctr + 2'd1;
		end else if (!taken && ctr != 2'b00) begin
			ctr_next = ctr - 2'd1;
		end
	endfunction

	// word aligned pc bits, the two low bits are always zero
	assign fetch_lht_idx = fetch_pc[branch_pkg::lht_len+1:2];
	assign train_lht_idx = train_pc[branch_pkg::lht_len+1:2];

	assign fetch_lhist = lht[fetch_lht_idx];
	assign train_lhist = lht[train_lht_idx];

	assign fetch_g_idx = fetch_pc[branch_pkg::ghist_len+1:2] ^ ghist;
	assign train_g_idx = train_pc[branch_pkg::ghist_len+1:2] ^ ghist;

	assign local_pred_taken  = lpt[fetch_lhist][1]; // msb is the prediction
	assign global_pred_taken = gpt[fetch_g_idx][1];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < branch_pkg::lht_size; i++) begin
				lht[i] <= '0;
			end
			for (int i = 0; i < branch_pkg::lpt_size; i++) begin
				lpt[i] <= branch_pkg::ctr_init;
			end
			for (int i = 0; i < branch_pkg::gpt_size; i++) begin
				gpt[i] <= branch_pkg::ctr_init;
			end
			ghist <= '0;
		end else if (train) begin
			// counter is picked by the history before this outcome
			lpt[train_lhist] <= ctr_next(lpt[train_lhist], train_taken);
			lht[train_lht_idx] <= {train_lhist[branch_pkg::lhist_len-2:0], train_taken};
			gpt[train_g_idx] <= ctr_next(gpt[train_g_idx], train_taken);
			ghist <= {ghist[branch_pkg::ghist_len-2:0], train_taken};
		end
	end

	// an X strobe here would corrupt every table entry it touches
	train_known: assert property (
		@(posedge clock) disable iff (!rst_n)
		!$isunknown(train)
	);

endmodule

`default_nettype wire

//--- hdl/branch_exec.sv
`timescale 1ns/100ps
`default_nettype none

module branch_exec (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          branch_enable,
	input  branch_pkg::rs_branch_packet_t rs_branch_packet,
	input  branch_pkg::word_t             fetch_pc,
	output logic                          br_valid,
	output branch_pkg::br_result_t        br_result,
	output logic                          local_pred_taken,
	output logic                          global_pred_taken
);

	branch_pkg::br_result_t br_result_comb; // unregistered resolution
	logic                   br_train;

	branch_unit branch_unit_i (
		.rs_branch_packet (rs_branch_packet),
		.br_result        (br_result_comb)
	);

	branch_result_reg branch_result_reg_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.branch_enable (branch_enable),
		.cond_branch   (rs_branch_packet.cond_branch),
		.br_result_in  (br_result_comb),
		.br_valid      (br_valid),
		.br_train      (br_train),
		.br_result     (br_result)
	);

	// trains from the registered outcome, one cycle after issue
	branch_predictor branch_predictor_i (
		.clock             (clock),
		.rst_n             (rst_n),
		.fetch_pc          (fetch_pc),
		.local_pred_taken  (local_pred_taken),
		.global_pred_taken (global_pred_taken),
		.train             (br_train),
		.train_pc          (br_result.pc),
		.train_taken       (br_result.direction)
	);

endmodule

`default_nettype wire

//--- tests/branch_exec_tb.sv
`timescale 1ns/100ps
`default_nettype none

module branch_exec_tb;

	localparam int clk_period  = 20;
	localparam int n_random    = 300; // packets per random test
	localparam int test_cycles = 60 + 4 * n_random; // longest possible run of all tests

	logic                          clock = 1'b0;
	logic                          rst_n;
	logic                          branch_enable;
	branch_pkg::rs_branch_packet_t rs_branch_packet;
	branch_pkg::word_t             fetch_pc;
	logic                          br_valid;
	branch_pkg::br_result_t        br_result;
	logic                          local_pred_taken;
	logic                          global_pred_taken;

	branch_pkg::rs_branch_packet_t last_pkt; // copy of the last issued packet
	logic   expect_valid;
	logic   pred_check;
	int     taken_trains; // resolved conditional branches seen by the predictor
	integer seed;
	int     error_count = 0;
	int     tests_run;
	int     tests_failed;

	branch_exec branch_exec_i (
		.clock             (clock),
		.rst_n             (rst_n),
		.branch_enable     (branch_enable),
		.rs_branch_packet  (rs_branch_packet),
		.fetch_pc          (fetch_pc),
		.br_valid          (br_valid),
		.br_result         (br_result),
		.local_pred_taken  (local_pred_taken),
		.global_pred_taken (global_pred_taken)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		if (branch_enable) begin
			last_pkt <= rs_branch_packet;
		end
	end

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			expect_valid <= 1'b0;
			taken_trains <= 0;
		end else begin
			expect_valid <= branch_enable;
			// tables change at the edge that ends the valid cycle
			if (expect_valid && last_pkt.cond_branch) begin
				taken_trains <= taken_trains + 1;
			end
		end
	end

	function automatic logic expect_cond(input branch_pkg::word_t a, input branch_pkg::word_t b,
		input branch_pkg::br_func_t func);
		case (func)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			3'b111: return a >= b;
			default: return 1'b0; // 010 and 011
		endcase
	endfunction

	function automatic logic expect_direction(input branch_pkg::rs_branch_packet_t pkt);
		return pkt.uncond_branch || expect_cond(pkt.opa_value, pkt.opb_value, pkt.branch_func);
	endfunction

	function automatic branch_pkg::word_t expect_target(input branch_pkg::rs_branch_packet_t pkt);
		if (!expect_direction(pkt)) begin
			return pkt.pc + 32'd4;
		end
		if (pkt.is_jalr) begin
			return pkt.opa_value + pkt.offset;
		end
		return pkt.pc + pkt.offset;
	endfunction

	function automatic branch_pkg::br_result_t expect_result(input branch_pkg::rs_branch_packet_t pkt);
		branch_pkg::br_result_t res;
		res.direction = expect_direction(pkt);
		res.target_pc = expect_target(pkt);
		res.prf_idx   = pkt.dest_preg_idx;
		res.value     = pkt.uncond_branch ? pkt.pc + 32'd4 : '0;
		res.rob_idx   = pkt.rob_idx;
		res.mis_pred  = pkt.pred_target_pc != res.target_pc;
		res.local_pred_direction  = pkt.local_pred_direction;
		res.global_pred_direction = pkt.global_pred_direction;
		res.pc        = pkt.pc;
		return res;
	endfunction

	task automatic report_mismatch(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		$display("ERR %s expected %0h actual %0h", name, expected, actual);
		error_count++;
	endtask

	result_rule: assert property (@(posedge clock) disable iff (!rst_n)
		br_valid |-> br_result == expect_result(last_pkt))
		else report_mismatch("br_result", 256'(expect_result($sampled(last_pkt))),
			256'($sampled(br_result)));

	valid_rule: assert property (@(posedge clock) disable iff (!rst_n) br_valid == expect_valid)
		else report_mismatch("br_valid", 256'($sampled(expect_valid)), 256'($sampled(br_valid)));

	valid_in_reset: assert property (@(negedge clock) !rst_n |-> !br_valid)
		else report_mismatch("br_valid", 256'(1'b0), 256'($sampled(br_valid)));

	// counts follow from zeroed histories and weakly not taken counters
	local_pred_rule: assert property (@(posedge clock) disable iff (!rst_n)
		pred_check |-> local_pred_taken == (taken_trains >= 5))
		else report_mismatch("local_pred_taken", 256'($sampled(taken_trains) >= 5),
			256'($sampled(local_pred_taken)));

	global_pred_rule: assert property (@(posedge clock) disable iff (!rst_n)
		pred_check |-> global_pred_taken == (taken_trains >= 7))
		else report_mismatch("global_pred_taken", 256'($sampled(taken_trains) >= 7),
			256'($sampled(global_pred_taken)));

	task automatic idle_cycle();
		@(posedge clock);
		branch_enable <= 1'b0;
	endtask

	task automatic issue_packet(input branch_pkg::rs_branch_packet_t pkt);
		@(posedge clock);
		branch_enable    <= 1'b1;
		rs_branch_packet <= pkt;
	endtask

	// kind 0 conditional, 1 jal, 2 jalr
	task automatic build_packet(input int kind, output branch_pkg::rs_branch_packet_t pkt);
		branch_pkg::word_t r;
		branch_pkg::word_t a;
		branch_pkg::word_t b;
		r = $random(seed);
		a = $random(seed);
		b = $random(seed);
		case (r[18:17])
			2'd1: b = a;
			2'd2: b = {~a[31], b[30:0]}; // opposite signs
			2'd3: begin
				a = r[19] ? 32'h8000_0000 : 32'd1; // signed and unsigned order disagree
				b = r[19] ? 32'd1 : 32'h8000_0000;
			end
			default: ;
		endcase
		pkt = '0;
		pkt.pc            = $random(seed) & 32'hffff_fffc;
		pkt.opa_value     = a;
		pkt.opb_value     = b;
		pkt.offset        = $random(seed);
		pkt.branch_func   = r[2:0];
		pkt.cond_branch   = kind == 0;
		pkt.uncond_branch = kind != 0;
		pkt.is_jalr       = kind == 2;
		pkt.dest_preg_idx = r[8:3];
		pkt.rob_idx       = r[13:9];
		pkt.local_pred_direction  = r[14];
		pkt.global_pred_direction = r[15];
		pkt.pred_target_pc = r[16] ? expect_target(pkt) : $random(seed); // half predicted right
	endtask

	task automatic finish_test(input string name, input int start_errors);
		idle_cycle();
		@(negedge clock);
		while (br_valid) begin // last broadcast still out
			@(negedge clock);
		end
		tests_run++;
		if (error_count != start_errors) begin
			tests_failed++;
		end
		$display("%s finished with %0d errors", name, error_count - start_errors);
	endtask

	task automatic train_predictor();
		branch_pkg::rs_branch_packet_t pkt;
		branch_pkg::word_t             train_pc;
		int                            start_errors;
		start_errors = error_count;
		train_pc = $random(seed) & 32'hffff_fffc;
		@(posedge clock);
		pred_check <= 1'b1;
		repeat (16) begin
			@(posedge clock);
			fetch_pc <= $random(seed); // untrained lookups anywhere
		end
		@(posedge clock);
		fetch_pc <= train_pc;
		for (int i = 0; i < 7; i++) begin
			build_packet(0, pkt);
			pkt.pc          = train_pc;
			pkt.opb_value   = pkt.opa_value;
			pkt.branch_func = 3'b000; // beq on equal operands
			issue_packet(pkt);
			build_packet(1, pkt);
			pkt.pc = train_pc; // jump at the same pc
			issue_packet(pkt);
			idle_cycle();
		end
		finish_test("predictor_training", start_errors);
		@(posedge clock);
		pred_check <= 1'b0;
	endtask

	task automatic run_random_test(input string name, input int mixed);
		branch_pkg::rs_branch_packet_t pkt;
		int                            start_errors;
		int                            kind;
		start_errors = error_count;
		for (int i = 0; i < n_random; i++) begin
			kind = mixed ? ($random(seed) & 32'h7fff_ffff) % 3 : 0;
			build_packet(kind, pkt);
			if (($random(seed) & 3) == 0) begin
				idle_cycle(); // gap, otherwise back to back
			end
			issue_packet(pkt);
		end
		finish_test(name, start_errors);
	endtask

	initial begin
		seed = 32'h342d_97b1;
		tests_run = 0;
		tests_failed = 0;
		rst_n <= 1'b0;
		branch_enable <= 1'b0;
		rs_branch_packet <= '0;
		fetch_pc <= '0;
		pred_check <= 1'b0;
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;
		train_predictor(); // needs fresh tables
		run_random_test("condition_rules", 0);
		run_random_test("target_link_mispredict", 1);
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(2 * test_cycles * clk_period);
		$display("watchdog expired before the tests completed");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
hdl/branch_pkg.sv
hdl/brcond.sv
hdl/branch_unit.sv
hdl/branch_result_reg.sv
hdl/branch_predictor.sv
hdl/branch_exec.sv
tests/branch_exec_tb.sv

//--- Makefile
TOP       ?= branch_exec_tb
FLIST     ?= flist.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
